// ==== verilog/lsu_pkg.sv ====
// load/store pipeline shared types
// widths, operation and fault codes, data-memory bus commands
// and the structs passed between the pipeline stages

`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [63:0]        data_t;    // one memory word
  typedef logic [63:0]        addr_t;    // byte address
  typedef logic signed [15:0] offset_t;  // immediate offset from the request
  typedef logic [3:0]         req_id_t;  // issuer's request id
  typedef logic [3:0]         mem_tag_t; // bus tag, zero is no tag

  localparam mem_tag_t last_tag = 4'd15; // tags run 1 .. last_tag then wrap

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    op_nop   = 3'd0,
    op_add   = 3'd1,
    op_load  = 3'd2,
    op_store = 3'd3    // 4..7 are illegal
  } lsu_op_e;

  typedef enum logic [1:0] {
    fault_none       = 2'd0,
    fault_illegal    = 2'd1,
    fault_misaligned = 2'd2,
    fault_range      = 2'd3
  } fault_e;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_e;

  //////////////////////////////////////////////////////////////////////
  // pipeline payloads
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    lsu_op_e op;
    addr_t   base;
    offset_t offset;
    data_t   store_data;
    req_id_t id;
  } lsu_request_t;

  typedef struct packed {
    logic    valid;
    logic    rd_mem;     // load
    logic    wr_mem;     // store
    logic    is_add;
    addr_t   base;
    addr_t   offset;     // already sign-extended
    data_t   store_data;
    req_id_t id;
    fault_e  fault;
  } decoded_t;

  typedef struct packed {
    logic    valid;
    logic    rd_mem;
    logic    wr_mem;
    addr_t   alu_result; // address for memory ops, sum for add
    data_t   store_data;
    req_id_t id;
    fault_e  fault;
  } executed_t;

  typedef struct packed {
    req_id_t id;
    data_t   data;
    fault_e  fault;
  } lsu_completion_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_decode.sv ====
// decode stage
// classifies the requested operation, sign-extends the offset
// and registers the control bits for execute

`default_nettype none

module lsu_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue,    // request strobe
  input  lsu_pkg::lsu_request_t request,
  input  logic                 hold,     // stall from the memory stage
  output lsu_pkg::decoded_t    decoded
);

  import lsu_pkg::*;

  localparam int ext_w = $bits(addr_t) - $bits(offset_t); // sign bits to add

  logic     accept;   // request taken this cycle
  decoded_t next_dec;

  assign accept = issue && !hold; // ready is the inverse of hold

  always_comb begin
    next_dec = '0; // idle cycle loads an invalid entry
    if (accept) begin
      next_dec.valid      = 1'b1;
      next_dec.base       = request.base;
      next_dec.offset     = {{ext_w{request.offset[$bits(offset_t)-1]}}, request.offset};
      next_dec.store_data = request.store_data;
      next_dec.id         = request.id;
      case (request.op)
        op_nop:   ;                            // completes with zero
        op_add:   next_dec.is_add = 1'b1;
        op_load:  next_dec.rd_mem = 1'b1;
        op_store: next_dec.wr_mem = 1'b1;
        default:  next_dec.fault  = fault_illegal; // no memory bits set
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      decoded <= '0;
    end else if (!hold) begin
      decoded <= next_dec;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_execute.sv ====
// execute stage
// forms base plus offset and checks loads and stores for
// alignment and for the data memory range

`default_nettype none

module lsu_execute #(
  parameter int mem_words = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               hold,
  input  lsu_pkg::decoded_t  decoded,
  output lsu_pkg::executed_t executed
);

  import lsu_pkg::*;

  addr_t     sum;
  logic      is_mem;
  executed_t next_ex;

  always_comb begin
    sum    = decoded.base + decoded.offset;
    is_mem = decoded.rd_mem || decoded.wr_mem;

    next_ex.valid      = decoded.valid;
    next_ex.rd_mem     = decoded.rd_mem;
    next_ex.wr_mem     = decoded.wr_mem;
    next_ex.alu_result = (decoded.is_add || is_mem) ? sum : '0; // nop carries zero
    next_ex.store_data = decoded.store_data;
    next_ex.id         = decoded.id;
    next_ex.fault      = decoded.fault;  // decode fault wins

    if (is_mem && decoded.fault == fault_none) begin
      if (sum[2:0] != 3'b000) begin
        next_ex.fault = fault_misaligned;
      end else if ((sum >> 3) >= addr_t'(mem_words)) begin
        next_ex.fault = fault_range;     // word index past the array
      end
    end

    // faulted accesses never reach the bus
    if (next_ex.fault != fault_none) begin
      next_ex.rd_mem = 1'b0;
      next_ex.wr_mem = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      executed <= '0;
    end else if (!hold) begin
      executed <= next_ex;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
// memory access stage
// drives the tagged data-memory bus, remembers the tag of the
// load in flight and stalls the pipe until its data returns

`default_nettype none

module mem_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  lsu_pkg::executed_t    executed,
  input  lsu_pkg::data_t        dmem_rdata,    // load data from memory
  input  lsu_pkg::mem_tag_t     dmem_rtag,     // tag of dmem_rdata, zero when idle
  input  lsu_pkg::mem_tag_t     dmem_response, // tag granted to this cycle's command
  output lsu_pkg::bus_command_e dmem_command,
  output lsu_pkg::addr_t        dmem_addr,
  output lsu_pkg::data_t        dmem_wdata,
  output lsu_pkg::data_t        mem_result,    // to the result stage
  output logic                  stall
);

  import lsu_pkg::*;

  mem_tag_t waiting_tag; // nonzero while a load waits for data
  logic     tag_write;

  //////////////////////////////////////////////////////////////////////
  // bus command
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (waiting_tag != '0) begin
      dmem_command = bus_none;   // load already sent
    end else if (executed.wr_mem) begin
      dmem_command = bus_store;
    end else if (executed.rd_mem) begin
      dmem_command = bus_load;
    end else begin
      dmem_command = bus_none;
    end
  end

  assign dmem_addr  = executed.alu_result;  // address from execute
  assign dmem_wdata = executed.store_data;

  //////////////////////////////////////////////////////////////////////
  // stall and result
  //////////////////////////////////////////////////////////////////////

  assign mem_result = executed.rd_mem ? dmem_rdata : executed.alu_result;

  assign stall = (executed.rd_mem && (waiting_tag != dmem_rtag || dmem_rtag == '0)) ||
                 (executed.wr_mem && dmem_response == '0);

  // take the tag on issue, drop it when the matching data shows up
  assign tag_write = executed.rd_mem && (waiting_tag == '0 || waiting_tag == dmem_rtag);

  always_ff @(posedge clock) begin
    if (reset) begin
      waiting_tag <= '0;
    end else if (tag_write) begin
      waiting_tag <= dmem_response; // zero on the return cycle, no command then
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tagged_dmem.sv ====
// behavioural data memory on a tagged bus
// word addressed, every command gets a fresh tag at once,
// load data returns load_latency cycles later with its tag

`default_nettype none

module tagged_dmem #(
  parameter int mem_words    = 32,
  parameter int load_latency = 3   // at least 1
) (
  input  logic                  clock,
  input  logic                  reset,
  input  lsu_pkg::bus_command_e dmem_command,
  input  lsu_pkg::addr_t        dmem_addr,
  input  lsu_pkg::data_t        dmem_wdata,
  output lsu_pkg::data_t        dmem_rdata,
  output lsu_pkg::mem_tag_t     dmem_rtag,
  output lsu_pkg::mem_tag_t     dmem_response
);

  import lsu_pkg::*;

  localparam int idx_w        = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int clear_lanes  = 4;  // words zeroed per reset cycle
  localparam int clear_groups = (mem_words + clear_lanes - 1) / clear_lanes;
  localparam int grp_w        = (clear_groups > 1) ? $clog2(clear_groups) : 1;

  typedef struct packed {
    mem_tag_t tag;
    data_t    data;
  } load_slot_t;

  data_t            mem [mem_words];
  logic [grp_w-1:0] clear_grp;         // group being zeroed
  logic [idx_w-1:0] word_idx;
  logic             in_range;
  data_t            load_word;
  mem_tag_t         next_tag;          // tag for the next command
  load_slot_t       pipe [load_latency]; // load return pipeline

  assign word_idx  = dmem_addr[idx_w+2:3];   // byte address to word
  assign in_range  = (dmem_addr >> 3) < addr_t'(mem_words);
  assign load_word = in_range ? mem[word_idx] : '0;

  assign dmem_response = (dmem_command != bus_none) ? next_tag : '0; // same cycle
  assign dmem_rtag     = pipe[load_latency-1].tag;
  assign dmem_rdata    = pipe[load_latency-1].data;

  //////////////////////////////////////////////////////////////////////
  // array, reset walk and stores
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    int slot;
    if (reset) begin
      for (int lane = 0; lane < clear_lanes; lane++) begin
        slot = int'(clear_grp) * clear_lanes + lane;
        if (slot < mem_words) mem[slot] <= '0;
      end
    end else if (dmem_command == bus_store && in_range) begin
      mem[word_idx] <= dmem_wdata;   // store lands at the command edge
    end
  end

  // counter rests at zero between resets so every walk starts at word 0
  always_ff @(posedge clock) begin
    if (reset) begin
      clear_grp <= (clear_grp == grp_w'(clear_groups - 1)) ? '0 : clear_grp + 1'b1;
    end else begin
      clear_grp <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tags and load return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= mem_tag_t'(1);
    end else if (dmem_command != bus_none) begin
      next_tag <= (next_tag == last_tag) ? mem_tag_t'(1) : next_tag + 1'b1; // skip zero
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < load_latency; i++) pipe[i].tag <= '0;
    end else begin
      pipe[0].tag <= (dmem_command == bus_load) ? next_tag : '0;
      for (int i = 1; i < load_latency; i++) pipe[i].tag <= pipe[i-1].tag;
    end
    pipe[0].data <= load_word;                 // only meaningful under a tag
    for (int i = 1; i < load_latency; i++) pipe[i].data <= pipe[i-1].data;
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_result.sv ====
// result stage
// registers one completion per request with its id, data
// and fault code, skipping cycles where the memory stage stalls

`default_nettype none

module lsu_result (
  input  logic                     clock,
  input  logic                     reset,
  input  lsu_pkg::executed_t       executed,
  input  lsu_pkg::data_t           mem_result,
  input  logic                     stall,
  output logic                     done,       // one strobe per request
  output lsu_pkg::lsu_completion_t completion
);

  import lsu_pkg::*;

  logic retire; // entry leaves the pipe this cycle

  assign retire = executed.valid && !stall;  // bubble while stalled

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= retire;
    end
  end

  always_ff @(posedge clock) begin
    if (retire) begin
      completion.id    <= executed.id;
      completion.fault <= executed.fault;
      // faulted requests report zero, nop already arrives as zero
      completion.data  <= (executed.fault != fault_none) ? '0 : mem_result;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
// load/store pipeline top level
// decode, execute, memory access and result stages around a
// behavioural tagged data memory

`default_nettype none

module lsu_top #(
  parameter int mem_words    = 32,
  parameter int load_latency = 3
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue,
  input  lsu_pkg::lsu_request_t    request,
  output logic                     ready,      // request taken when high
  output logic                     done,
  output lsu_pkg::lsu_completion_t completion
);

  import lsu_pkg::*;

  decoded_t     decoded;
  executed_t    executed;
  bus_command_e dmem_command;
  addr_t        dmem_addr;
  data_t        dmem_wdata;
  data_t        dmem_rdata;
  mem_tag_t     dmem_rtag;
  mem_tag_t     dmem_response;
  data_t        mem_result;
  logic         stall;

  assign ready = !stall;

  lsu_decode decode0 (
    .clock   (clock),
    .reset   (reset),
    .issue   (issue),
    .request (request),
    .hold    (stall),
    .decoded (decoded)
  );

  lsu_execute #(.mem_words(mem_words)) execute0 (
    .clock    (clock),
    .reset    (reset),
    .hold     (stall),
    .decoded  (decoded),
    .executed (executed)
  );

  mem_stage mem0 (
    .clock         (clock),
    .reset         (reset),
    .executed      (executed),
    .dmem_rdata    (dmem_rdata),
    .dmem_rtag     (dmem_rtag),
    .dmem_response (dmem_response),
    .dmem_command  (dmem_command),
    .dmem_addr     (dmem_addr),
    .dmem_wdata    (dmem_wdata),
    .mem_result    (mem_result),
    .stall         (stall)
  );

  tagged_dmem #(.mem_words(mem_words), .load_latency(load_latency)) dmem0 (
    .clock         (clock),
    .reset         (reset),
    .dmem_command  (dmem_command),
    .dmem_addr     (dmem_addr),
    .dmem_wdata    (dmem_wdata),
    .dmem_rdata    (dmem_rdata),
    .dmem_rtag     (dmem_rtag),
    .dmem_response (dmem_response)
  );

  lsu_result result0 (
    .clock      (clock),
    .reset      (reset),
    .executed   (executed),
    .mem_result (mem_result),
    .stall      (stall),
    .done       (done),
    .completion (completion)
  );

endmodule

`default_nettype wire

// ==== verification/lsu_assertions.sv ====
// memory stage bus checks
// command and stall rules of the tagged data-memory bus

`default_nettype none

module lsu_assertions (
  input logic                  clock,
  input logic                  reset,
  input lsu_pkg::bus_command_e dmem_command,
  input lsu_pkg::mem_tag_t     dmem_response, // tag granted to this cycle's command
  input lsu_pkg::mem_tag_t     dmem_rtag,     // tag of returning load data
  input logic                  stall
);

  import lsu_pkg::*;

  mem_tag_t open_tag; // load tag seen on the bus and not yet returned

  // follows the load in flight from the bus side
  always_ff @(posedge clock) begin
    if (reset) begin
      open_tag <= '0;
    end else if (dmem_command == bus_load) begin
      open_tag <= dmem_response;
    end else if (open_tag != '0 && dmem_rtag == open_tag) begin
      open_tag <= '0;  // data came back
    end
  end

  // one load on the bus at a time
  no_command_while_waiting: assert property (@(posedge clock) disable iff (reset)
    (open_tag != '0) |-> (dmem_command == bus_none))
    else $error("bus command while a load tag is waiting");

  // a stall always has an access on the bus or a load in flight
  stall_needs_memory_op: assert property (@(posedge clock) disable iff (reset)
    stall |-> (dmem_command != bus_none || open_tag != '0))
    else $error("stall without a memory access in the stage");

  idle_after_reset: assert property (@(posedge clock)
    reset |=> (dmem_command == bus_none))
    else $error("bus command in the cycle after reset");

endmodule

bind mem_stage lsu_assertions asserts0 (
  .clock         (clock),
  .reset         (reset),
  .dmem_command  (dmem_command),
  .dmem_response (dmem_response),
  .dmem_rtag     (dmem_rtag),
  .stall         (stall)
);

`default_nettype wire

// ==== verification/lsu_tb.sv ====
// load/store pipeline testbench
// table-driven requests plus a seeded random mix, checked in order
// against a golden word array kept by the testbench

`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  localparam int mem_words      = 32;   // dut0 runs with its defaults
  localparam int load_latency   = 3;
  localparam int table_rows     = 24;
  localparam int random_rows    = 40;
  localparam int timeout_cycles = (table_rows + random_rows) * (load_latency + 8) + 50;

  typedef struct packed {
    logic [2:0] op;         // raw encoding, so illegal codes fit
    addr_t      base;
    offset_t    offset;
    data_t      store_data;
  } stim_row_t;

  logic            clock;
  logic            reset;
  logic            issue;
  lsu_request_t    request;
  logic            ready;
  logic            done;
  lsu_completion_t completion;

  stim_row_t       stim [table_rows];
  data_t           golden [mem_words];  // memory as the rules say it should be
  lsu_completion_t expected_q [$];      // one entry per accepted request
  req_id_t         next_id;
  int              issued;
  int              completed;
  int              cycles = 0;

  lsu_top dut0 (
    .clock      (clock),
    .reset      (reset),
    .issue      (issue),
    .request    (request),
    .ready      (ready),
    .done       (done),
    .completion (completion)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_id(input string name, input req_id_t got, input req_id_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_fault(input string name, input fault_e got, input fault_e exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // golden model and driver
  //////////////////////////////////////////////////////////////////////

  // expected completion by the stage rules, stores update the golden array
  function automatic lsu_completion_t predict_completion(input logic [2:0] op,
      input addr_t base, input offset_t offset, input data_t store_data, input req_id_t id);
    lsu_completion_t exp;
    addr_t           addr;
    addr  = base + {{48{offset[15]}}, offset};  // offset is sign-extended
    exp   = '{id: id, data: '0, fault: fault_none};
    case (op)
      op_nop: ;                                   // zero data, no fault
      op_add: exp.data = addr;
      op_load, op_store: begin
        if (addr[2:0] != 3'b000) begin
          exp.fault = fault_misaligned;
        end else if (addr >= addr_t'(mem_words * 8)) begin
          exp.fault = fault_range;
        end else if (op == op_load) begin
          exp.data = golden[addr[7:3]];
        end else begin
          golden[addr[7:3]] = store_data;
          exp.data = addr;                        // a store reports its address
        end
      end
      default: exp.fault = fault_illegal;
    endcase
    return exp;
  endfunction

  // issue on the first falling edge with ready high
  task automatic send_request(input logic [2:0] op, input addr_t base,
      input offset_t offset, input data_t store_data);
    @(negedge clock);
    issue = 1'b0;
    while (!ready) @(negedge clock);
    request.op         = lsu_op_e'(op);
    request.base       = base;
    request.offset     = offset;
    request.store_data = store_data;
    request.id         = next_id;
    issue              = 1'b1;
    expected_q.push_back(predict_completion(op, base, offset, store_data, next_id));
    next_id = next_id + 1'b1;  // wraps after 15
    issued++;
  endtask

  task automatic fill_table();
    stim[0]  = '{3'd1, 64'h1000, 16'sh0024, 64'h0};                // add
    stim[1]  = '{3'd1, 64'h0500, -16'sd16, 64'h0};                 // add, negative offset
    stim[2]  = '{3'd1, 64'h0, 16'sh8000, 64'h0};                   // most negative offset
    stim[3]  = '{3'd3, 64'h40, 16'sh0008, 64'hdead_beef_0123_4567};
    stim[4]  = '{3'd2, 64'h50, -16'sd8, 64'h0};                    // same word back
    stim[5]  = '{3'd2, 64'h80, 16'sh0000, 64'h0};                  // never written
    stim[6]  = '{3'd3, 64'h20, 16'sh0003, 64'haaaa_bbbb_cccc_dddd}; // misaligned
    stim[7]  = '{3'd2, 64'h20, 16'sh0000, 64'h0};                  // still zero
    stim[8]  = '{3'd3, 64'h100, 16'sh0000, 64'h1111_2222_3333_4444}; // out of range
    stim[9]  = '{3'd2, 64'h0, 16'sh0000, 64'h0};                   // no wrap to word 0
    stim[10] = '{3'd5, 64'h10, 16'sh0000, 64'h5};                  // illegal
    stim[11] = '{3'd7, 64'h18, 16'sh0008, 64'h7};
    stim[12] = '{3'd0, 64'h30, 16'sh0008, 64'h9};                  // nop
    stim[13] = '{3'd2, 64'h08, 16'sh0001, 64'h0};
    stim[14] = '{3'd2, 64'h0, 16'sh0200, 64'h0};
    stim[15] = '{3'd3, 64'hf8, 16'sh0000, 64'h0f0f_0f0f_f0f0_f0f0}; // last word
    stim[16] = '{3'd2, 64'hf8, 16'sh0000, 64'h0};
    stim[17] = '{3'd1, 64'hffff_ffff_ffff_fff0, 16'sh0020, 64'h0}; // wraps to 0x10
    stim[18] = '{3'd3, 64'h10, 16'sh0000, 64'h0123_0000_0000_0010};
    stim[19] = '{3'd3, 64'h18, 16'sh0000, 64'h0123_0000_0000_0018};
    stim[20] = '{3'd2, 64'h10, 16'sh0000, 64'h0};
    stim[21] = '{3'd1, 64'h7, 16'sh0009, 64'h0};
    stim[22] = '{3'd2, 64'h18, 16'sh0000, 64'h0};
    stim[23] = '{3'd2, 64'h100, -16'sd8, 64'h0};
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor, timeout and main sequence
  //////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    lsu_completion_t exp;
    if (!reset && done) begin
      if (expected_q.size() == 0) begin
        $display("done was raised with no request outstanding");
        stop_with_failure();
      end else begin
        exp = expected_q.pop_front();            // completions come in issue order
        check_id("completion.id", completion.id, exp.id);
        check_fault("completion.fault", completion.fault, exp.fault);
        check_data("completion.data", completion.data, exp.data);
        completed++;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("the run hung, no progress after %0d cycles", cycles);
      stop_with_failure();
    end
  end

  initial begin
    logic [31:0] r;
    logic [4:0]  idx;
    logic [3:0]  k;
    reset     = 1'b1;
    issue     = 1'b0;
    request   = '0;
    next_id   = '0;
    issued    = 0;
    completed = 0;
    void'($urandom(32'h924a3925));
    for (int i = 0; i < mem_words; i++) golden[i] = '0;
    fill_table();
    repeat (10) @(negedge clock);
    reset = 1'b0;
    repeat (3) begin                              // quiet and ready before any issue
      @(negedge clock);
      check_bit("done", done, 1'b0);
      check_bit("ready", ready, 1'b1);
    end
    for (int i = 0; i < table_rows; i++) begin
      send_request(stim[i].op, stim[i].base, stim[i].offset, stim[i].store_data);
    end
    for (int i = 0; i < random_rows; i++) begin
      r   = $urandom;
      idx = r[4:0];                               // word index
      k   = r[8:5];                               // split the address over base and offset
      send_request(r[9] ? 3'd3 : 3'd2, addr_t'({idx, 3'b000}) + addr_t'({k, 3'b000}),
                   offset_t'(-8 * int'(k)), {$urandom, $urandom});
    end
    @(negedge clock);
    issue = 1'b0;
    while (completed != issued) @(negedge clock);
    repeat (load_latency + 4) @(negedge clock);  // a stray done would hit the monitor
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_execute.sv
verilog/mem_stage.sv
verilog/tagged_dmem.sv
verilog/lsu_result.sv
verilog/lsu_top.sv
verification/lsu_assertions.sv
verification/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the load/store pipeline testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/Vlsu_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
